// ==== Makefile ====
# Verilator build and run for the systolic MAC engine

VERILATOR ?= verilator
TOP       ?= mac_array_tb
FILELIST  ?= mac_array_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/mac_array_sva.sv ====
`timescale 1ns/10ps

module mac_array_sva import mac_pkg::*; (
    input logic     clk_i,
    input logic     rst_i,
    input logic     cmd_valid_i,
    input mac_cmd_t cmd_i,
    input logic     res_valid_i
);

    logic compute_strobe;

    // only compute commands produce a result
    assign compute_strobe = cmd_valid_i && (cmd_i.op == OP_COMPUTE);

    // output stays quiet while reset is held and one cycle after
    a_quiet_reset: assert property (@(posedge clk_i) rst_i |=> !res_valid_i)
        else $error("result strobe during or right after reset");

    // every compute strobe comes back after the fixed latency
    a_result_follows: assert property (@(posedge clk_i) disable iff (rst_i)
        $past(compute_strobe, MAC_LATENCY) |-> res_valid_i)
        else $error("result strobe missing %0d cycles after a compute", MAC_LATENCY);

    // and no strobe appears without one
    a_no_stray_result: assert property (@(posedge clk_i) disable iff (rst_i)
        res_valid_i |-> $past(compute_strobe, MAC_LATENCY))
        else $error("result strobe with no compute %0d cycles earlier", MAC_LATENCY);

endmodule

bind mac_array_top mac_array_sva sva0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .res_valid_i (res_valid_o)
);

// ==== bench/mac_array_tb.sv ====
`timescale 1ns/10ps

module mac_array_tb import mac_pkg::*; ();

    localparam int DRAIN_LIMIT = 4 * MAC_LATENCY;

    // one table row, drain holds off the next row until all results are back
    typedef struct packed {
        mac_cmd_t cmd;
        logic     drain;
    } stim_entry_t;

    logic        clk_i;
    logic        rst_i;
    logic        cmd_valid_i;
    mac_cmd_t    cmd_i;
    logic        res_valid_o;
    sum_vec_t    res_o;

    int          seed = 70548;
    int          cycle_cnt = 0;
    int          err_cnt = 0;
    stim_entry_t stim_table [$];
    // expected vectors and issue cycles, in command order
    sum_vec_t    exp_q [$];
    int          issue_q [$];
    // reference copy of the weight grid, row r at index r
    weight_vec_t w_model [MAC_N];

    mac_array_top dut0 (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .res_valid_o (res_valid_o),
        .res_o       (res_o)
    );

    always #20 clk_i = ~clk_i;

    // free-running cycle count for latency measurement
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic stop_with_failure();
        $display("tests failed");
        $fatal(1);
    endtask

    function automatic act_vec_t gen_acts();
        act_vec_t v;
        for (int c = 0; c < MAC_N; c++) begin
            v[c] = act_t'($random(seed));
        end
        return v;
    endfunction

    function automatic weight_vec_t random_weights();
        weight_vec_t v;
        for (int c = 0; c < MAC_N; c++) begin
            v[c] = weight_t'($random(seed));
        end
        return v;
    endfunction

    task automatic push_weight_load(input weight_vec_t wv, input logic drain);
        stim_entry_t e;
        e.cmd.op      = OP_LOAD_W;
        e.cmd.weights = wv;
        e.cmd.acts    = '0;
        e.drain       = drain;
        stim_table.push_back(e);
    endtask

    task automatic queue_compute(input act_vec_t xv, input logic drain);
        stim_entry_t e;
        e.cmd.op      = OP_COMPUTE;
        e.cmd.weights = '0;
        e.cmd.acts    = xv;
        e.drain       = drain;
        stim_table.push_back(e);
    endtask

    task automatic build_table();
        weight_vec_t wv;
        // identity, k-th load is row k
        for (int k = 0; k < MAC_N; k++) begin
            wv    = '0;
            wv[k] = 8'd1;
            push_weight_load(wv, 1'b0);
        end
        for (int i = 0; i < 3; i++) begin
            queue_compute(gen_acts(), i == 2);
        end
        // random matrix, then a burst of eight back-to-back computes
        for (int k = 0; k < MAC_N; k++) begin
            push_weight_load(random_weights(), 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            queue_compute(gen_acts(), i == 3);
        end
        for (int i = 0; i < 8; i++) begin
            queue_compute(gen_acts(), i == 7);
        end
        // worst case operands, no truncation allowed
        for (int k = 0; k < MAC_N; k++) begin
            push_weight_load('1, 1'b0);
        end
        for (int i = 0; i < 2; i++) begin
            queue_compute('1, i == 1);
        end
        // reload after drain
        for (int k = 0; k < MAC_N; k++) begin
            push_weight_load(random_weights(), 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            queue_compute(gen_acts(), i == 3);
        end
    endtask

    // drive one row and advance the reference model
    task automatic apply_entry(input stim_entry_t e);
        sum_vec_t y;
        sum_t     acc;
        cmd_valid_i = 1'b1;
        cmd_i       = e.cmd;
        if (e.cmd.op == OP_LOAD_W) begin
            // new vector enters the bottom row, the rest move up
            for (int r = 0; r < MAC_N - 1; r++) begin
                w_model[r] = w_model[r+1];
            end
            w_model[MAC_N-1] = e.cmd.weights;
        end else begin
            for (int r = 0; r < MAC_N; r++) begin
                acc = '0;
                for (int c = 0; c < MAC_N; c++) begin
                    acc = acc + sum_t'(w_model[r][c]) * sum_t'(e.cmd.acts[c]);
                end
                y[r] = acc;
            end
            exp_q.push_back(y);
            issue_q.push_back(cycle_cnt);
        end
    endtask

    task automatic wait_drain(input int entry);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk_i);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: results after table entry %0d did not drain in %0d cycles",
                     entry, DRAIN_LIMIT);
            stop_with_failure();
        end
    endtask

    task automatic check_result(input sum_vec_t got, input sum_vec_t want);
        int bad;
        bad = -1;
        // lowest mismatching element wins
        for (int r = MAC_N - 1; r >= 0; r--) begin
            if (got[r] !== want[r]) bad = r;
        end
        if (bad >= 0) begin
            err_cnt++;
            $display("Error: %0d ns: result element %0d is %0d, expected %0d",
                     $time, bad, got[bad], want[bad]);
            stop_with_failure();
        end
    endtask

    task automatic check_latency(input int got, input int want);
        if (got != want) begin
            err_cnt++;
            $display("Error: %0d ns: result latency is %0d cycles, expected %0d",
                     $time, got, want);
            stop_with_failure();
        end
    endtask

    // outputs settle after the rising edge, look at them on the falling one
    always @(negedge clk_i) begin
        if (res_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("result strobe seen with no compute command outstanding");
                stop_with_failure();
            end else begin
                check_latency(cycle_cnt - issue_q.pop_front(), MAC_LATENCY);
                check_result(res_o, exp_q.pop_front());
            end
        end
    end

    initial begin
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        for (int r = 0; r < MAC_N; r++) begin
            w_model[r] = '0;
        end
        build_table();
        // reset over four rising edges
        repeat (4) @(negedge clk_i);
        rst_i = 1'b0;
        // quiet period, no commands yet
        for (int i = 0; i < 3 * MAC_LATENCY; i++) begin
            @(negedge clk_i);
            if (res_valid_o !== 1'b0) begin
                $display("res_valid_o was not low while idle after reset");
                stop_with_failure();
            end
        end
        for (int i = 0; i < stim_table.size(); i++) begin
            @(negedge clk_i);
            apply_entry(stim_table[i]);
            if (stim_table[i].drain) begin
                @(negedge clk_i);
                cmd_valid_i = 1'b0;
                cmd_i       = '0;
                wait_drain(i);
            end
        end
        if (err_cnt == 0 && exp_q.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

// ==== hw/mac_array_top.sv ====
`timescale 1ns/10ps

module mac_array_top import mac_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,

    // single-cycle command strobe, always accepted
    input  logic     cmd_valid_i,
    input  mac_cmd_t cmd_i,

    // result strobe, MAC_LATENCY cycles after a compute command
    output logic     res_valid_o,
    output sum_vec_t res_o
);

    // decode to grid
    logic        wload;
    weight_vec_t wvec;
    logic        act_valid;
    act_vec_t    skewed_act;

    // grid to deskew
    logic        row_valid;
    sum_vec_t    row_sum;

    // command register, opcode split and activation skew
    mac_cmd_decode u_decode (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_i),
        .wload_o      (wload),
        .wvec_o       (wvec),
        .act_valid_o  (act_valid),
        .skewed_act_o (skewed_act)
    );

    // weight-stationary grid
    systolic_array u_array (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .wload_i     (wload),
        .wvec_i      (wvec),
        .act_valid_i (act_valid),
        .act_i       (skewed_act),
        .row_sum_o   (row_sum),
        .row_valid_o (row_valid)
    );

    // row deskew and output register
    result_align u_result (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .row_valid_i (row_valid),
        .row_sum_i   (row_sum),
        .res_valid_o (res_valid_o),
        .res_o       (res_o)
    );

endmodule

// ==== hw/mac_cell.sv ====
`timescale 1ns/10ps

module mac_cell import mac_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,

    // stationary weight, shifted up from the row below
    input  logic    wload_i,
    input  weight_t weight_i,
    output weight_t weight_o,

    // activation from the row above, forwarded down
    input  act_t    act_i,
    output act_t    act_o,

    // partial sum from the left, registered to the right
    input  sum_t    sum_i,
    output sum_t    sum_o
);

    weight_t weight_q;
    act_t    act_q;
    sum_t    sum_q;

    // weight only moves on a load strobe
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            weight_q <= '0;
        end else if (wload_i) begin
            weight_q <= weight_i;
        end
    end

    // multiply-accumulate and activation forward, every cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            act_q <= '0;
            sum_q <= '0;
        end else begin
            act_q <= act_i;
            // zero-extend both operands before the multiply
            sum_q <= sum_t'(act_i) * sum_t'(weight_q) + sum_i;
        end
    end

    // held weight feeds the row above
    assign weight_o = weight_q;
    assign act_o    = act_q;
    assign sum_o    = sum_q;

endmodule

// ==== hw/mac_cmd_decode.sv ====
`timescale 1ns/10ps

module mac_cmd_decode import mac_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,

    // command strobe from outside, no back-pressure
    input  logic        cmd_valid_i,
    input  mac_cmd_t    cmd_i,

    // weight load towards the bottom row
    output logic        wload_o,
    output weight_vec_t wvec_o,

    // skewed activations towards row 0
    output logic        act_valid_o,
    output act_vec_t    skewed_act_o
);

    logic     valid_q;
    mac_cmd_t cmd_q;
    act_vec_t act_masked;

    // strobe register, cleared on reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= cmd_valid_i;
        end
    end

    // command payload, only meaningful while valid_q is high
    always_ff @(posedge clk_i) begin
        if (cmd_valid_i) begin
            cmd_q <= cmd_i;
        end
    end

    // split by opcode, both strobes at t0+1
    assign wload_o     = valid_q && (cmd_q.op == OP_LOAD_W);
    assign act_valid_o = valid_q && (cmd_q.op == OP_COMPUTE);

    // weights go straight to the bottom row
    assign wvec_o = cmd_q.weights;

    // zero columns on idle or load cycles
    // so nothing stray enters the grid
    assign act_masked = act_valid_o ? cmd_q.acts : '0;

    // column c delayed by c cycles
    // column 0 is a plain wire, aligned with act_valid_o
    generate
        for (genvar c = 0; c < MAC_N; c++) begin : g_col
            skew_line #(
                .payload_t (act_t),
                .DEPTH     (c)
            ) u_act_skew (
                .clk_i (clk_i),
                .rst_i (rst_i),
                .d_i   (act_masked[c]),
                .q_o   (skewed_act_o[c])
            );
        end
    endgenerate

endmodule

// ==== hw/mac_pkg.sv ====
package mac_pkg;

    // array is MAC_N rows by MAC_N columns
    localparam int MAC_N   = 4;

    // operand and accumulator widths, all unsigned
    localparam int W_WIDTH = 8;
    localparam int A_WIDTH = 16;
    localparam int S_WIDTH = 32;

    // command strobe to result strobe, in cycles
    // one decode register, MAC_N through the grid for row 0,
    // MAC_N - 1 of deskew, one result register
    localparam int MAC_LATENCY = 2 * MAC_N + 1;

    typedef logic [W_WIDTH-1:0] weight_t;
    typedef logic [A_WIDTH-1:0] act_t;
    typedef logic [S_WIDTH-1:0] sum_t;

    // 1-bit opcode
    typedef enum logic {
        OP_LOAD_W  = 1'b0,
        OP_COMPUTE = 1'b1
    } mac_op_e;

    // element c sits at index c
    typedef weight_t [MAC_N-1:0] weight_vec_t;
    typedef act_t    [MAC_N-1:0] act_vec_t;
    typedef sum_t    [MAC_N-1:0] sum_vec_t;

    // weights only matter for loads, acts only for computes
    typedef struct packed {
        mac_op_e     op;
        weight_vec_t weights;
        act_vec_t    acts;
    } mac_cmd_t;

endpackage

// ==== hw/result_align.sv ====
`timescale 1ns/10ps

module result_align import mac_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,

    // row 0 complete, rows below arrive one cycle apart each
    input  logic     row_valid_i,
    input  sum_vec_t row_sum_i,

    // aligned result vector
    output logic     res_valid_o,
    output sum_vec_t res_o
);

    sum_vec_t         aligned;
    // valid waits for the last row
    logic [MAC_N-2:0] valid_sr;

    // row r is late by r cycles, so delay it MAC_N-1-r more
    // the last row passes straight through
    generate
        for (genvar r = 0; r < MAC_N; r++) begin : g_row
            skew_line #(
                .payload_t (sum_t),
                .DEPTH     (MAC_N - 1 - r)
            ) u_sum_deskew (
                .clk_i (clk_i),
                .rst_i (rst_i),
                .d_i   (row_sum_i[r]),
                .q_o   (aligned[r])
            );
        end
    endgenerate

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[MAC_N-3:0], row_valid_i};
        end
    end

    // output strobe, MAC_LATENCY after the command
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= valid_sr[MAC_N-2];
        end
    end

    // result payload, loaded with each aligned strobe
    always_ff @(posedge clk_i) begin
        if (valid_sr[MAC_N-2]) begin
            res_o <= aligned;
        end
    end

endmodule

// ==== hw/skew_line.sv ====
`timescale 1ns/10ps

module skew_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  payload_t d_i,
    output payload_t q_o
);

    generate
        if (DEPTH == 0) begin : g_wire
            // no delay for this lane
            assign q_o = d_i;
        end else begin : g_regs
            // stage 0 is nearest the input
            payload_t stage_q [DEPTH];

            always_ff @(posedge clk_i) begin
                if (rst_i) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stage_q[i] <= '0;
                    end
                end else begin
                    stage_q[0] <= d_i;
                    // shift the rest of the chain by one
                    for (int i = 1; i < DEPTH; i++) begin
                        stage_q[i] <= stage_q[i-1];
                    end
                end
            end

            // oldest stage drives the output
            assign q_o = stage_q[DEPTH-1];
        end
    endgenerate

endmodule

// ==== hw/systolic_array.sv ====
`timescale 1ns/10ps

module systolic_array import mac_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,

    // weight vector enters the bottom row
    input  logic        wload_i,
    input  weight_vec_t wvec_i,

    // skewed activations enter row 0
    input  logic        act_valid_i,
    input  act_vec_t    act_i,

    // rightmost column sum of every row
    output sum_vec_t    row_sum_o,
    output logic        row_valid_o
);

    // w_link[r] feeds row r-1, w_link[MAC_N] is the external vector
    weight_t w_link [MAC_N+1][MAC_N];
    // a_link[r] is the activation into row r
    act_t    a_link [MAC_N+1][MAC_N];
    // s_link[r][c] is the partial sum into column c of row r
    sum_t    s_link [MAC_N][MAC_N+1];
    // one stage per row of latency through column 0
    logic [MAC_N-1:0] valid_sr;

    generate
        for (genvar c = 0; c < MAC_N; c++) begin : g_edge_col
            assign w_link[MAC_N][c] = wvec_i[c];
            assign a_link[0][c]     = act_i[c];
        end

        for (genvar r = 0; r < MAC_N; r++) begin : g_row
            // no bias, column 0 starts from zero
            assign s_link[r][0] = '0;
            assign row_sum_o[r] = s_link[r][MAC_N];

            for (genvar c = 0; c < MAC_N; c++) begin : g_col
                mac_cell u_cell (
                    .clk_i    (clk_i),
                    .rst_i    (rst_i),
                    .wload_i  (wload_i),
                    // take from below, hand upward
                    .weight_i (w_link[r+1][c]),
                    .weight_o (w_link[r][c]),
                    // take from above, hand downward
                    .act_i    (a_link[r][c]),
                    .act_o    (a_link[r+1][c]),
                    // take from the left, hand rightward
                    .sum_i    (s_link[r][c]),
                    .sum_o    (s_link[r][c+1])
                );
            end
        end
    endgenerate

    // row 0 result leaves column MAC_N-1 after MAC_N cycles
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[MAC_N-2:0], act_valid_i};
        end
    end

    assign row_valid_o = valid_sr[MAC_N-1];

endmodule

// ==== mac_array_top.f ====
hw/mac_pkg.sv
hw/skew_line.sv
hw/mac_cmd_decode.sv
hw/mac_cell.sv
hw/systolic_array.sv
hw/result_align.sv
hw/mac_array_top.sv
bench/mac_array_sva.sv
bench/mac_array_tb.sv
